//--- frame_edit.f
source/frame_edit_pkg.sv
source/script_matcher.sv
source/instr_select.sv
source/operand_gather.sv
source/field_rewrite.sv
source/frame_edit_top.sv
test/frame_edit_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" \
	&& verilator --binary --timing -Wno-fatal --top-module frame_edit_tb -f frame_edit.f \
		-o frame_edit_sim \
	&& ./obj_dir/frame_edit_sim \
	|| exit 1

//--- test/frame_edit_tb.sv
/*
	Random frames of 16 to 96 bytes against a behavioral model of the editor.
	Edit fields are kept inside their frame, so no window is cut short.
	Scripts are rewritten only while s_valid is low.
*/
module frame_edit_tb;

	localparam int MAX_LEN = 96;
	localparam int NUM_FRAMES = 4 + 6 * 4 * 2 + 2 * 4 * 2 + 6 + 4 + 10;
	// Per frame at most four script writes, the bytes and two idle cycles
	localparam int FRAME_CYCLES = 4 + MAX_LEN + 2;
	localparam int STIM_CYCLES = 8 + NUM_FRAMES * FRAME_CYCLES
		+ frame_edit_pkg::PIPE_LATENCY + 4;
	localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + 200;

	logic clk;
	logic rst_n;
	logic [7:0] s_data;
	logic s_valid;
	logic s_last;
	logic s_bad;
	logic cfg_wr;
	logic [frame_edit_pkg::SCRIPT_IDX_W-1:0] cfg_script;
	logic [frame_edit_pkg::OFFSET_W-1:0] cfg_offset;
	frame_edit_pkg::edit_op_e cfg_op;
	frame_edit_pkg::field_width_e cfg_width;
	logic cfg_signed;
	logic cfg_big_endian;
	logic [frame_edit_pkg::PARAM_W-1:0] cfg_param;
	logic [7:0] m_data;
	logic [7:0] m_orig;
	logic m_valid;
	logic m_last;
	logic m_drop;
	logic m_corrupt;

	// Shadow copy of the script table
	frame_edit_pkg::edit_op_e sc_op [frame_edit_pkg::NUM_SCRIPTS];
	frame_edit_pkg::field_width_e sc_width [frame_edit_pkg::NUM_SCRIPTS];
	bit sc_signed [frame_edit_pkg::NUM_SCRIPTS];
	bit sc_big [frame_edit_pkg::NUM_SCRIPTS];
	int sc_offset [frame_edit_pkg::NUM_SCRIPTS];
	logic [63:0] sc_param [frame_edit_pkg::NUM_SCRIPTS];

	logic [7:0] frame_buf [128];
	logic [7:0] exp_data_q [$];
	logic [2:0] exp_flag_q [$];
	string name_q [$];
	logic [7:0] in_byte_q [$];
	int in_cycle_q [$];
	int cycle;
	int seed;

	frame_edit_top frame_edit_top_inst (.*);

	always #10 clk = ~clk;

	function automatic int rand_range(int lo, int hi);
		return lo + int'({$random(seed)} % (hi - lo + 1));
	endfunction

	function automatic bit rand_bit();
		return 1'($random(seed));
	endfunction

	function automatic logic [63:0] rand64();
		return {32'($random(seed)), 32'($random(seed))};
	endfunction

	function automatic int width_bytes(frame_edit_pkg::field_width_e w);
		case (w)
			frame_edit_pkg::W1: return 1;
			frame_edit_pkg::W2: return 2;
			frame_edit_pkg::W4: return 4;
			default: return 8;
		endcase
	endfunction

	function automatic logic [63:0] extend(logic [63:0] v, int n, bit sgn);
		logic [63:0] keep;
		keep = (n == 8) ? '1 : ((64'd1 << (8 * n)) - 64'd1);
		if (sgn && v[8 * n - 1]) begin
			return v | ~keep;
		end
		return v & keep;
	endfunction

	// Expected output of one frame under the current scripts
	function automatic void model_frame(string name, int len, bit bad);
		logic [7:0] out [128];
		logic [63:0] val, prm, res;
		int p, n, sel, i, k, b;
		bit sgn, lt, drop, corrupt, last;
		drop = 1'b0;
		corrupt = bad;
		for (i = 0; i < len; i++) begin
			out[i] = frame_buf[i];
		end
		p = 0;
		while (p < len) begin
			sel = -1;
			for (i = frame_edit_pkg::NUM_SCRIPTS - 1; i >= 0; i--) begin
				if (sc_op[i] != frame_edit_pkg::OP_NONE && sc_offset[i] == p) begin
					sel = i;
				end
			end
			if (sel < 0) begin
				p++;
			end else if (sc_op[sel] == frame_edit_pkg::OP_DROP) begin
				drop = 1'b1;
				p++;
			end else if (sc_op[sel] == frame_edit_pkg::OP_CORRUPT) begin
				corrupt = 1'b1;
				p++;
			end else begin
				n = width_bytes(sc_width[sel]);
				sgn = sc_signed[sel];
				val = '0;
				for (k = 0; k < n; k++) begin
					b = sc_big[sel] ? n - 1 - k : k;
					val[8 * b +: 8] = out[p + k];
				end
				val = extend(val, n, sgn);
				prm = extend(sc_param[sel], n, sgn);
				lt = sgn ? ($signed(val) < $signed(prm)) : (val < prm);
				case (sc_op[sel])
					frame_edit_pkg::OP_SET: res = prm;
					frame_edit_pkg::OP_ADD: res = val + prm;
					frame_edit_pkg::OP_SUB: res = val - prm;
					frame_edit_pkg::OP_XOR: res = val ^ prm;
					frame_edit_pkg::OP_AND: res = val & prm;
					frame_edit_pkg::OP_OR: res = val | prm;
					frame_edit_pkg::OP_MIN: res = lt ? val : prm;
					default: res = lt ? prm : val;
				endcase
				for (k = 0; k < n; k++) begin
					b = sc_big[sel] ? n - 1 - k : k;
					out[p + k] = res[8 * b +: 8];
				end
				p = p + n;
			end
		end
		for (i = 0; i < len; i++) begin
			last = (i == len - 1);
			exp_data_q.push_back(out[i]);
			exp_flag_q.push_back({last, last && drop, last && corrupt});
			name_q.push_back(name);
		end
	endfunction

	task automatic check_byte(string what, logic [7:0] exp, logic [7:0] act);
		if (act !== exp) begin
			$display("ERROR %s: expected %02h actual %02h", what, exp, act);
			$display("Simulation failed");
			$fatal(1, "byte mismatch");
		end
	endtask

	task automatic check_flags(string what, logic [2:0] exp, logic [2:0] act);
		if (act !== exp) begin
			$display("ERROR %s last/drop/corrupt: expected %03b actual %03b", what, exp, act);
			$display("Simulation failed");
			$fatal(1, "flag mismatch");
		end
	endtask

	task automatic check_latency(string what, int exp, int act);
		if (act != exp) begin
			$display("ERROR %s latency: expected %0d actual %0d", what, exp, act);
			$display("Simulation failed");
			$fatal(1, "latency mismatch");
		end
	endtask

	task automatic idle(int n);
		repeat (n) begin
			@(posedge clk);
			s_valid <= 1'b0;
			s_last <= 1'b0;
			s_bad <= 1'b0;
			cfg_wr <= 1'b0;
		end
	endtask

	task automatic write_script(int idx, frame_edit_pkg::edit_op_e op,
			frame_edit_pkg::field_width_e w, bit sgn, bit be, int off, logic [63:0] prm);
		sc_op[idx] = op;
		sc_width[idx] = w;
		sc_signed[idx] = sgn;
		sc_big[idx] = be;
		sc_offset[idx] = off;
		sc_param[idx] = prm;
		@(posedge clk);
		s_valid <= 1'b0;
		s_last <= 1'b0;
		s_bad <= 1'b0;
		cfg_wr <= 1'b1;
		cfg_script <= 2'(idx);
		cfg_op <= op;
		cfg_width <= w;
		cfg_signed <= sgn;
		cfg_big_endian <= be;
		cfg_offset <= 11'(off);
		cfg_param <= prm;
	endtask

	task automatic clear_scripts();
		for (int i = 0; i < frame_edit_pkg::NUM_SCRIPTS; i++) begin
			write_script(i, frame_edit_pkg::OP_NONE, frame_edit_pkg::W1, 1'b0, 1'b0, 0, '0);
		end
	endtask

	task automatic fill_random(int len);
		for (int i = 0; i < len; i++) begin
			frame_buf[i] = 8'($random(seed));
		end
	endtask

	task automatic send_frame(string name, int len, bit bad);
		model_frame(name, len, bad);
		for (int i = 0; i < len; i++) begin
			@(posedge clk);
			s_data <= frame_buf[i];
			s_valid <= 1'b1;
			s_last <= (i == len - 1);
			s_bad <= bad && (i == len - 1);
			cfg_wr <= 1'b0;
		end
	endtask

	// Records input bytes and compares every output byte
	always @(posedge clk) begin
		cycle = cycle + 1;
		if (cycle > TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, output stream did not finish", cycle);
			$display("Simulation failed");
			$fatal(1, "timeout");
		end
		if (rst_n && s_valid) begin
			in_byte_q.push_back(s_data);
			in_cycle_q.push_back(cycle);
		end
		if (rst_n && m_valid) begin
			if (in_byte_q.size() == 0 || exp_data_q.size() == 0) begin
				$display("Output byte appeared with no input byte waiting for it");
				$display("Simulation failed");
				$fatal(1, "stray output");
			end
			check_latency(name_q[0], frame_edit_pkg::PIPE_LATENCY,
				cycle - in_cycle_q.pop_front());
			check_byte({name_q[0], " data"}, exp_data_q.pop_front(), m_data);
			check_byte({name_q[0], " orig"}, in_byte_q.pop_front(), m_orig);
			check_flags(name_q.pop_front(), exp_flag_q.pop_front(), {m_last, m_drop, m_corrupt});
		end
	end

	initial begin
		int len, len_b, off, n, o, w, sg, f, i;
		bit be, s;
		logic [63:0] prm;
		frame_edit_pkg::field_width_e wid;
		frame_edit_pkg::edit_op_e op;
		seed = 83268;
		cycle = 0;
		clk = 1'b0;
		rst_n = 1'b0;
		s_data = '0;
		s_valid = 1'b0;
		s_last = 1'b0;
		s_bad = 1'b0;
		cfg_wr = 1'b0;
		cfg_script = '0;
		cfg_offset = '0;
		cfg_op = frame_edit_pkg::OP_NONE;
		cfg_width = frame_edit_pkg::W1;
		cfg_signed = 1'b0;
		cfg_big_endian = 1'b0;
		cfg_param = '0;
		for (i = 0; i < frame_edit_pkg::NUM_SCRIPTS; i++) begin
			sc_op[i] = frame_edit_pkg::OP_NONE;
			sc_width[i] = frame_edit_pkg::W1;
			sc_signed[i] = 1'b0;
			sc_big[i] = 1'b0;
			sc_offset[i] = 0;
			sc_param[i] = '0;
		end
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		idle(2);

		for (f = 0; f < 4; f++) begin
			len = rand_range(16, MAX_LEN);
			fill_random(len);
			send_frame("pass_through", len, 1'b0);
			idle(1);
		end

		for (o = int'(frame_edit_pkg::OP_SET); o <= int'(frame_edit_pkg::OP_OR); o++) begin
			for (w = 0; w < 4; w++) begin
				for (i = 0; i < 2; i++) begin
					op = frame_edit_pkg::edit_op_e'(o);
					wid = frame_edit_pkg::field_width_e'(w);
					n = width_bytes(wid);
					len = rand_range(16, MAX_LEN);
					off = rand_range(0, len - n);
					write_script(0, op, wid, rand_bit(), 1'(i), off, rand64());
					fill_random(len);
					send_frame($sformatf("edit %s w%0d be%0d", op.name(), n, i), len, 1'b0);
				end
			end
		end

		// Field and parameter get opposite sign bits
		for (o = 0; o < 2; o++) begin
			for (w = 0; w < 4; w++) begin
				op = (o == 0) ? frame_edit_pkg::OP_MIN : frame_edit_pkg::OP_MAX;
				wid = frame_edit_pkg::field_width_e'(w);
				n = width_bytes(wid);
				be = rand_bit();
				s = rand_bit();
				len = rand_range(16, MAX_LEN);
				off = rand_range(0, len - n);
				fill_random(len);
				frame_buf[be ? off : off + n - 1][7] = s;
				prm = rand64();
				prm[8 * n - 1] = !s;
				for (sg = 0; sg < 2; sg++) begin
					write_script(0, op, wid, 1'(sg), be, off, prm);
					send_frame($sformatf("%s w%0d signed%0d", op.name(), n, sg), len, 1'b0);
				end
			end
		end

		// Short frames after a flagged one never reach the flag offset
		clear_scripts();
		off = rand_range(20, 40);
		write_script(0, frame_edit_pkg::OP_DROP, frame_edit_pkg::W4, 1'b0, 1'b0, off, '0);
		write_script(1, frame_edit_pkg::OP_SET, frame_edit_pkg::W1, 1'b0, 1'b0, off + 1, rand64());
		len = rand_range(off + 2, MAX_LEN);
		fill_random(len);
		send_frame("drop", len, 1'b0);
		len = rand_range(16, off);
		fill_random(len);
		send_frame("after_drop", len, 1'b0);
		write_script(0, frame_edit_pkg::OP_CORRUPT, frame_edit_pkg::W8, 1'b0, 1'b1, off, '0);
		len = rand_range(off + 2, MAX_LEN);
		fill_random(len);
		send_frame("corrupt", len, 1'b0);
		len = rand_range(16, off);
		fill_random(len);
		send_frame("after_corrupt", len, 1'b0);
		clear_scripts();
		len = rand_range(16, MAX_LEN);
		fill_random(len);
		send_frame("bad_input", len, 1'b1);
		len = rand_range(16, MAX_LEN);
		fill_random(len);
		send_frame("after_bad", len, 1'b0);
		idle(1);

		// Scripts 1 and 2 start together and script 0 lands inside the window
		for (f = 0; f < 4; f++) begin
			len = rand_range(40, MAX_LEN);
			off = rand_range(0, len - 8);
			wid = frame_edit_pkg::field_width_e'(rand_range(1, 3));
			n = width_bytes(wid);
			write_script(1, frame_edit_pkg::edit_op_e'(rand_range(1, 8)), wid, rand_bit(),
				rand_bit(), off, rand64());
			write_script(2, frame_edit_pkg::edit_op_e'(rand_range(1, 8)), frame_edit_pkg::W8,
				rand_bit(), rand_bit(), off, rand64());
			write_script(0, frame_edit_pkg::OP_XOR, frame_edit_pkg::W1, 1'b0, rand_bit(),
				off + rand_range(1, n - 1), '1);
			write_script(3, frame_edit_pkg::OP_DROP, frame_edit_pkg::W1, 1'b0, 1'b0,
				rand_range(len, 2047), '0);
			fill_random(len);
			send_frame("priority", len, 1'b0);
		end

		for (f = 0; f < 5; f++) begin
			len = rand_range(16, MAX_LEN);
			len_b = rand_range(16, MAX_LEN);
			n = (len < len_b) ? len : len_b;
			for (i = 0; i < frame_edit_pkg::NUM_SCRIPTS; i++) begin
				write_script(i, frame_edit_pkg::edit_op_e'(rand_range(0, 10)),
					frame_edit_pkg::field_width_e'(rand_range(0, 3)), rand_bit(), rand_bit(),
					rand_range(0, n - 8), rand64());
			end
			fill_random(len);
			send_frame($sformatf("back_to_back %0d first", f), len, rand_bit());
			fill_random(len_b);
			send_frame($sformatf("back_to_back %0d second", f), len_b, 1'b0);
		end

		idle(1);
		while (exp_data_q.size() != 0) begin
			@(posedge clk);
		end
		// Quiet period to catch stray output bytes
		idle(frame_edit_pkg::PIPE_LATENCY + 4);
		if (exp_data_q.size() == 0 && in_byte_q.size() == 0) begin
			$display("Simulation passed");
			$finish;
		end else begin
			$display("Input bytes left without a matching output byte");
			$display("Simulation failed");
			$fatal(1, "unmatched input");
		end
	end

endmodule

//--- source/frame_edit_top.sv
/*
	In-line frame editor, one byte per cycle with no back-pressure.
	Every byte leaves frame_edit_pkg::PIPE_LATENCY (13) cycles after entry.
	s_valid must stay high for a whole frame. Scripts change between frames
	only, and fields never overlap.
*/
module frame_edit_top (
	input logic clk,
	input logic rst_n,

	input logic [7:0] s_data,
	input logic s_valid,
	input logic s_last,
	input logic s_bad,

	input logic cfg_wr,
	input logic [frame_edit_pkg::SCRIPT_IDX_W-1:0] cfg_script,
	input logic [frame_edit_pkg::OFFSET_W-1:0] cfg_offset,
	input frame_edit_pkg::edit_op_e cfg_op,
	input frame_edit_pkg::field_width_e cfg_width,
	input logic cfg_signed,
	input logic cfg_big_endian,
	input logic [frame_edit_pkg::PARAM_W-1:0] cfg_param,

	output logic [7:0] m_data,
	output logic [7:0] m_orig,
	output logic m_valid,
	output logic m_last,
	output logic m_drop,
	output logic m_corrupt
);
	// Matcher to select, 1 cycle after input
	logic [7:0] match_data;
	logic match_valid, match_last, match_bad;
	logic [frame_edit_pkg::NUM_SCRIPTS-1:0] match_hit;
	frame_edit_pkg::edit_op_e match_op [frame_edit_pkg::NUM_SCRIPTS];
	frame_edit_pkg::field_width_e match_width [frame_edit_pkg::NUM_SCRIPTS];
	logic [frame_edit_pkg::NUM_SCRIPTS-1:0] match_signed;
	logic [frame_edit_pkg::NUM_SCRIPTS-1:0] match_big_endian;
	logic [7:0] match_param_byte [frame_edit_pkg::NUM_SCRIPTS];

	// Select to gather, 2 cycles
	logic [7:0] sel_data;
	logic sel_valid, sel_last, sel_bad, sel_field_start;
	frame_edit_pkg::edit_op_e sel_op;
	frame_edit_pkg::field_width_e sel_width;
	logic sel_signed, sel_big_endian;
	logic [7:0] sel_param_byte;

	// Gather to rewrite, 11 cycles
	logic [7:0] gather_data;
	logic gather_valid, gather_last, gather_bad, gather_field_start;
	frame_edit_pkg::edit_op_e gather_op;
	frame_edit_pkg::field_width_e gather_width;
	logic gather_signed, gather_big_endian;
	logic [frame_edit_pkg::PARAM_W-1:0] gather_op_data;
	logic [frame_edit_pkg::PARAM_W-1:0] gather_op_param;

	script_matcher script_matcher_inst (.*);

	instr_select instr_select_inst (.*);

	operand_gather operand_gather_inst (.*);

	field_rewrite field_rewrite_inst (.*);

endmodule

//--- source/field_rewrite.sv
/*
	Executes the field operation and rewrites the field bytes in place.
	Drop and corrupt flags are valid on the last byte only and are
	cleared for the next frame.
*/
module field_rewrite (
	input logic clk,
	input logic rst_n,

	input logic [7:0] gather_data,
	input logic gather_valid,
	input logic gather_last,
	input logic gather_bad,
	input logic gather_field_start,
	input frame_edit_pkg::edit_op_e gather_op,
	input frame_edit_pkg::field_width_e gather_width,
	input logic gather_signed,
	input logic gather_big_endian,
	input logic [frame_edit_pkg::PARAM_W-1:0] gather_op_data,
	input logic [frame_edit_pkg::PARAM_W-1:0] gather_op_param,

	output logic [7:0] m_data,
	output logic [7:0] m_orig,
	output logic m_valid,
	output logic m_last,
	output logic m_drop,
	output logic m_corrupt
);
	logic [frame_edit_pkg::PARAM_W-1:0] res, wire_res, res_q;
	logic [3:0] nb;
	logic [2:0] bi;
	logic [2:0] rem;
	logic lt, is_edit, edit_start;
	logic drop_acc, corrupt_acc, cur_drop, cur_corrupt;
	logic [7:0] a_data;
	logic a_valid, a_last, a_sub, a_drop, a_corrupt;

	always_comb begin
		// Unsigned fields arrive zero-extended, so only W8 needs the unsigned compare
		lt = gather_signed ? ($signed(gather_op_data) < $signed(gather_op_param))
			: (gather_op_data < gather_op_param);
		case (gather_op)
			frame_edit_pkg::OP_SET: res = gather_op_param;
			frame_edit_pkg::OP_ADD: res = gather_op_data + gather_op_param;
			frame_edit_pkg::OP_SUB: res = gather_op_data - gather_op_param;
			frame_edit_pkg::OP_XOR: res = gather_op_data ^ gather_op_param;
			frame_edit_pkg::OP_AND: res = gather_op_data & gather_op_param;
			frame_edit_pkg::OP_OR: res = gather_op_data | gather_op_param;
			frame_edit_pkg::OP_MIN: res = lt ? gather_op_data : gather_op_param;
			frame_edit_pkg::OP_MAX: res = lt ? gather_op_param : gather_op_data;
			default: res = gather_op_data;
		endcase
	end

	// Truncate and lay out in wire order, first byte lowest
	always_comb begin
		nb = frame_edit_pkg::field_bytes(gather_width);
		wire_res = '0;
		for (int k = 0; k < 8; k++) begin
			bi = gather_big_endian ? 3'(nb - 4'd1 - 4'(k)) : 3'(k);
			if (k < nb) begin
				wire_res[8*k +: 8] = res[8*bi +: 8];
			end
		end
	end

	assign is_edit = gather_op != frame_edit_pkg::OP_NONE && gather_op != frame_edit_pkg::OP_DROP
		&& gather_op != frame_edit_pkg::OP_CORRUPT;
	assign edit_start = gather_valid && gather_field_start && is_edit;
	assign cur_drop = drop_acc
		|| (gather_valid && gather_field_start && gather_op == frame_edit_pkg::OP_DROP);
	assign cur_corrupt = corrupt_acc || gather_bad
		|| (gather_valid && gather_field_start && gather_op == frame_edit_pkg::OP_CORRUPT);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rem <= 3'd0;
			drop_acc <= 1'b0;
			corrupt_acc <= 1'b0;
			a_valid <= 1'b0;
			a_last <= 1'b0;
			a_sub <= 1'b0;
			a_drop <= 1'b0;
			a_corrupt <= 1'b0;
		end else begin
			a_valid <= gather_valid;
			a_last <= gather_valid && gather_last;
			a_sub <= edit_start || (gather_valid && rem != 3'd0);
			a_drop <= gather_valid && gather_last && cur_drop;
			a_corrupt <= gather_valid && gather_last && cur_corrupt;
			if (gather_valid) begin
				if (gather_last) begin
					rem <= 3'd0;
					drop_acc <= 1'b0;
					corrupt_acc <= 1'b0;
				end else begin
					drop_acc <= cur_drop;
					corrupt_acc <= cur_corrupt;
					if (edit_start) begin
						rem <= 3'(nb - 4'd1);
					end else if (rem != 3'd0) begin
						rem <= rem - 3'd1;
					end
				end
			end
		end
	end

	// Result shifts down one byte per window byte
	always_ff @(posedge clk) begin
		a_data <= gather_data;
		if (edit_start) begin
			res_q <= wire_res;
		end else begin
			res_q <= {8'd0, res_q[frame_edit_pkg::PARAM_W-1:8]};
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			m_valid <= 1'b0;
			m_last <= 1'b0;
			m_drop <= 1'b0;
			m_corrupt <= 1'b0;
		end else begin
			m_valid <= a_valid;
			m_last <= a_last;
			m_drop <= a_drop;
			m_corrupt <= a_corrupt;
		end
	end

	always_ff @(posedge clk) begin
		m_data <= a_sub ? res_q[7:0] : a_data;
		m_orig <= a_data;
	end

endmodule

//--- source/operand_gather.sv
/*
	Eight-byte delay line that collects a whole field before it is used.
	Operands appear with the start byte, nine cycles after input.
	Bytes past a window that a frame end cut short are read from the stream.
*/
module operand_gather (
	input logic clk,
	input logic rst_n,

	input logic [7:0] sel_data,
	input logic sel_valid,
	input logic sel_last,
	input logic sel_bad,
	input logic sel_field_start,
	input frame_edit_pkg::edit_op_e sel_op,
	input frame_edit_pkg::field_width_e sel_width,
	input logic sel_signed,
	input logic sel_big_endian,
	input logic [7:0] sel_param_byte,

	output logic [7:0] gather_data,
	output logic gather_valid,
	output logic gather_last,
	output logic gather_bad,
	output logic gather_field_start,
	output frame_edit_pkg::edit_op_e gather_op,
	output frame_edit_pkg::field_width_e gather_width,
	output logic gather_signed,
	output logic gather_big_endian,
	output logic [frame_edit_pkg::PARAM_W-1:0] gather_op_data,
	output logic [frame_edit_pkg::PARAM_W-1:0] gather_op_param
);
	logic [7:0] line_data [8];
	logic [7:0] line_param [8];
	frame_edit_pkg::edit_op_e line_op [8];
	frame_edit_pkg::field_width_e line_width [8];
	logic [7:0] line_valid, line_last, line_bad, line_start;
	logic [7:0] line_signed, line_big_endian;

	logic [frame_edit_pkg::PARAM_W-1:0] asm_data, asm_param;
	logic [3:0] nb;
	logic [2:0] bi;
	logic sign_d, sign_p;

	// Slot 0 is the newest byte
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			line_valid <= '0;
			line_last <= '0;
			line_bad <= '0;
			line_start <= '0;
		end else begin
			line_valid <= {line_valid[6:0], sel_valid};
			line_last <= {line_last[6:0], sel_last};
			line_bad <= {line_bad[6:0], sel_bad};
			line_start <= {line_start[6:0], sel_field_start};
		end
	end

	always_ff @(posedge clk) begin
		line_data[0] <= sel_data;
		line_param[0] <= sel_param_byte;
		line_op[0] <= sel_op;
		line_width[0] <= sel_width;
		line_signed <= {line_signed[6:0], sel_signed};
		line_big_endian <= {line_big_endian[6:0], sel_big_endian};
		for (int i = 1; i < 8; i++) begin
			line_data[i] <= line_data[i-1];
			line_param[i] <= line_param[i-1];
			line_op[i] <= line_op[i-1];
			line_width[i] <= line_width[i-1];
		end
	end

	// Wire byte k of a field starting in slot 7 sits in slot 7-k
	always_comb begin
		nb = frame_edit_pkg::field_bytes(line_width[7]);
		asm_data = '0;
		asm_param = '0;
		for (int k = 0; k < 8; k++) begin
			bi = line_big_endian[7] ? 3'(nb - 4'd1 - 4'(k)) : 3'(k);
			if (k < nb) begin
				asm_data[8*bi +: 8] = line_data[7-k];
				asm_param[8*bi +: 8] = line_param[7-k];
			end
		end
		sign_d = line_signed[7] && asm_data[8*nb-1];
		sign_p = line_signed[7] && asm_param[8*nb-1];
		for (int b = 1; b < 8; b++) begin
			if (b >= nb) begin
				asm_data[8*b +: 8] = {8{sign_d}};
				asm_param[8*b +: 8] = {8{sign_p}};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			gather_valid <= 1'b0;
			gather_last <= 1'b0;
			gather_bad <= 1'b0;
			gather_field_start <= 1'b0;
		end else begin
			gather_valid <= line_valid[7];
			gather_last <= line_last[7];
			gather_bad <= line_bad[7];
			gather_field_start <= line_start[7];
		end
	end

	always_ff @(posedge clk) begin
		gather_data <= line_data[7];
		gather_op <= line_op[7];
		gather_width <= line_width[7];
		gather_signed <= line_signed[7];
		gather_big_endian <= line_big_endian[7];
		gather_op_data <= asm_data;
		gather_op_param <= asm_param;
	end

endmodule

//--- source/instr_select.sv
/*
	Picks one script per field, lowest index first.
	Hits arriving while a window is open are dropped, and every window
	closes on the last byte of a frame.
*/
module instr_select (
	input logic clk,
	input logic rst_n,

	input logic [7:0] match_data,
	input logic match_valid,
	input logic match_last,
	input logic match_bad,
	input logic [frame_edit_pkg::NUM_SCRIPTS-1:0] match_hit,
	input frame_edit_pkg::edit_op_e match_op [frame_edit_pkg::NUM_SCRIPTS],
	input frame_edit_pkg::field_width_e match_width [frame_edit_pkg::NUM_SCRIPTS],
	input logic [frame_edit_pkg::NUM_SCRIPTS-1:0] match_signed,
	input logic [frame_edit_pkg::NUM_SCRIPTS-1:0] match_big_endian,
	input logic [7:0] match_param_byte [frame_edit_pkg::NUM_SCRIPTS],

	output logic [7:0] sel_data,
	output logic sel_valid,
	output logic sel_last,
	output logic sel_bad,
	output logic sel_field_start,
	output frame_edit_pkg::edit_op_e sel_op,
	output frame_edit_pkg::field_width_e sel_width,
	output logic sel_signed,
	output logic sel_big_endian,
	output logic [7:0] sel_param_byte
);
	logic [2:0] rem;
	logic [frame_edit_pkg::SCRIPT_IDX_W-1:0] held_idx;
	logic [frame_edit_pkg::SCRIPT_IDX_W-1:0] grant_idx;
	logic [frame_edit_pkg::SCRIPT_IDX_W-1:0] act_idx;
	logic [3:0] grant_len;
	logic any_hit;
	logic grant;
	logic act;

	always_comb begin
		any_hit = 1'b0;
		grant_idx = '0;
		// Downward scan leaves the lowest hitting index
		for (int i = frame_edit_pkg::NUM_SCRIPTS - 1; i >= 0; i--) begin
			if (match_hit[i]) begin
				any_hit = 1'b1;
				grant_idx = i[frame_edit_pkg::SCRIPT_IDX_W-1:0];
			end
		end
	end

	assign grant = match_valid && rem == 3'd0 && any_hit;
	assign act = grant || (match_valid && rem != 3'd0);
	assign act_idx = (rem == 3'd0) ? grant_idx : held_idx;
	assign grant_len = frame_edit_pkg::window_len(match_op[grant_idx], match_width[grant_idx]);

	// Bytes still to come in the open window
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rem <= 3'd0;
			held_idx <= '0;
		end else if (match_valid) begin
			if (grant) begin
				held_idx <= grant_idx;
			end
			if (match_last) begin
				rem <= 3'd0;
			end else if (grant) begin
				rem <= 3'(grant_len - 4'd1);
			end else if (rem != 3'd0) begin
				rem <= rem - 3'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sel_valid <= 1'b0;
			sel_last <= 1'b0;
			sel_bad <= 1'b0;
			sel_field_start <= 1'b0;
			sel_op <= frame_edit_pkg::OP_NONE;
		end else begin
			sel_valid <= match_valid;
			sel_last <= match_last;
			sel_bad <= match_bad;
			sel_field_start <= grant;
			sel_op <= act ? match_op[act_idx] : frame_edit_pkg::OP_NONE;
		end
	end

	always_ff @(posedge clk) begin
		sel_data <= match_data;
		sel_width <= match_width[act_idx];
		sel_signed <= match_signed[act_idx];
		sel_big_endian <= match_big_endian[act_idx];
		sel_param_byte <= match_param_byte[act_idx];
	end

endmodule

//--- source/script_matcher.sv
/*
	Script table and per-script start detection.
	Scripts may only be written between frames. Byte positions count from
	zero after reset or after a byte with s_last.
*/
module script_matcher (
	input logic clk,
	input logic rst_n,

	input logic [7:0] s_data,
	input logic s_valid,
	input logic s_last,
	input logic s_bad,

	input logic cfg_wr,
	input logic [frame_edit_pkg::SCRIPT_IDX_W-1:0] cfg_script,
	input logic [frame_edit_pkg::OFFSET_W-1:0] cfg_offset,
	input frame_edit_pkg::edit_op_e cfg_op,
	input frame_edit_pkg::field_width_e cfg_width,
	input logic cfg_signed,
	input logic cfg_big_endian,
	input logic [frame_edit_pkg::PARAM_W-1:0] cfg_param,

	output logic [7:0] match_data,
	output logic match_valid,
	output logic match_last,
	output logic match_bad,
	output logic [frame_edit_pkg::NUM_SCRIPTS-1:0] match_hit,
	output frame_edit_pkg::edit_op_e match_op [frame_edit_pkg::NUM_SCRIPTS],
	output frame_edit_pkg::field_width_e match_width [frame_edit_pkg::NUM_SCRIPTS],
	output logic [frame_edit_pkg::NUM_SCRIPTS-1:0] match_signed,
	output logic [frame_edit_pkg::NUM_SCRIPTS-1:0] match_big_endian,
	output logic [7:0] match_param_byte [frame_edit_pkg::NUM_SCRIPTS]
);
	frame_edit_pkg::edit_op_e tbl_op [frame_edit_pkg::NUM_SCRIPTS];
	frame_edit_pkg::field_width_e tbl_width [frame_edit_pkg::NUM_SCRIPTS];
	logic [frame_edit_pkg::NUM_SCRIPTS-1:0] tbl_signed;
	logic [frame_edit_pkg::NUM_SCRIPTS-1:0] tbl_big_endian;
	logic [frame_edit_pkg::OFFSET_W-1:0] tbl_offset [frame_edit_pkg::NUM_SCRIPTS];
	logic [frame_edit_pkg::PARAM_W-1:0] tbl_param [frame_edit_pkg::NUM_SCRIPTS];

	logic [frame_edit_pkg::OFFSET_W-1:0] pos;
	logic [frame_edit_pkg::NUM_SCRIPTS-1:0] start;
	logic [frame_edit_pkg::NUM_SCRIPTS-1:0] win_act;
	logic [2:0] win_k [frame_edit_pkg::NUM_SCRIPTS];
	logic [2:0] cur_k [frame_edit_pkg::NUM_SCRIPTS];
	logic [2:0] pidx [frame_edit_pkg::NUM_SCRIPTS];
	logic [3:0] win_len [frame_edit_pkg::NUM_SCRIPTS];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < frame_edit_pkg::NUM_SCRIPTS; i++) begin
				tbl_op[i] <= frame_edit_pkg::OP_NONE;
			end
		end else if (cfg_wr) begin
			tbl_op[cfg_script] <= cfg_op;
		end
	end

	always_ff @(posedge clk) begin
		if (cfg_wr) begin
			tbl_width[cfg_script] <= cfg_width;
			tbl_signed[cfg_script] <= cfg_signed;
			tbl_big_endian[cfg_script] <= cfg_big_endian;
			tbl_offset[cfg_script] <= cfg_offset;
			tbl_param[cfg_script] <= cfg_param;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pos <= '0;
		end else if (s_valid) begin
			pos <= s_last ? '0 : pos + 1'b1;
		end
	end

	always_comb begin
		for (int i = 0; i < frame_edit_pkg::NUM_SCRIPTS; i++) begin
			start[i] = s_valid && tbl_op[i] != frame_edit_pkg::OP_NONE && pos == tbl_offset[i];
			win_len[i] = frame_edit_pkg::window_len(tbl_op[i], tbl_width[i]);
			cur_k[i] = start[i] ? 3'd0 : win_k[i];
			// Big-endian fields put the top parameter byte on the wire first
			pidx[i] = tbl_big_endian[i] ? 3'(win_len[i] - 4'd1 - {1'b0, cur_k[i]}) : cur_k[i];
		end
	end

	// Wire byte index inside each script's window
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			win_act <= '0;
			for (int i = 0; i < frame_edit_pkg::NUM_SCRIPTS; i++) begin
				win_k[i] <= 3'd0;
			end
		end else if (s_valid) begin
			for (int i = 0; i < frame_edit_pkg::NUM_SCRIPTS; i++) begin
				if (start[i] || win_act[i]) begin
					win_k[i] <= cur_k[i] + 3'd1;
					win_act[i] <= !s_last && ({1'b0, cur_k[i]} + 4'd1 < win_len[i]);
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			match_valid <= 1'b0;
			match_last <= 1'b0;
			match_bad <= 1'b0;
			match_hit <= '0;
		end else begin
			match_valid <= s_valid;
			match_last <= s_valid && s_last;
			match_bad <= s_valid && s_last && s_bad;
			match_hit <= start;
		end
	end

	always_ff @(posedge clk) begin
		match_data <= s_data;
		match_signed <= tbl_signed;
		match_big_endian <= tbl_big_endian;
		for (int i = 0; i < frame_edit_pkg::NUM_SCRIPTS; i++) begin
			match_op[i] <= tbl_op[i];
			match_width[i] <= tbl_width[i];
			match_param_byte[i] <= tbl_param[i][8*pidx[i] +: 8];
		end
	end

endmodule

//--- source/frame_edit_pkg.sv
/*
	Sizes and encodings shared by the frame editor stages.
	Four scripts, fields of 1, 2, 4 or 8 bytes, offsets up to 2047.
*/
package frame_edit_pkg;

	localparam int NUM_SCRIPTS = 4;
	localparam int SCRIPT_IDX_W = 2;
	localparam int OFFSET_W = 11;
	localparam int PARAM_W = 64;

	// Cycles from an input byte to the same byte on m_data
	localparam int PIPE_LATENCY = 13;

	typedef enum logic [3:0] {
		OP_NONE,
		OP_SET,
		OP_ADD,
		OP_SUB,
		OP_XOR,
		OP_AND,
		OP_OR,
		OP_MIN,
		OP_MAX,
		// Frame flags only, data passes unchanged
		OP_DROP,
		OP_CORRUPT
	} edit_op_e;

	typedef enum logic [1:0] {
		W1,
		W2,
		W4,
		W8
	} field_width_e;

	function automatic logic [3:0] field_bytes(field_width_e w);
		return 4'd1 << w;
	endfunction

	// Bytes covered by a script's window
	function automatic logic [3:0] window_len(edit_op_e op, field_width_e w);
		if (op == OP_DROP || op == OP_CORRUPT) begin
			return 4'd1;
		end
		return field_bytes(w);
	endfunction

endpackage
